// File: hdl/dbg_uart_settings.svh
`ifndef DBG_UART_SETTINGS_SVH
`define DBG_UART_SETTINGS_SVH

// ------------------------------------------------------------
// serial link
// ------------------------------------------------------------

// uart_clk cycles per bit on rx and tx
`define DBG_BAUD_DIV 12

// ------------------------------------------------------------
// debug controller
// ------------------------------------------------------------

// number of PC breakpoints
`define DBG_NUM_BP 4

// injection entries and the length of the step window in cycles
`define DBG_INJECT_DEPTH 24

`endif

// File: hdl/dbg_uart_pkg.sv
package dbg_uart_pkg;

	// one byte on the bus or the serial line
	typedef logic [7:0] dbg_byte_t;

	// cpu address for pc, sp and breakpoints
	typedef logic [15:0] dbg_addr_t;

	// report half, flags and the report sequence counter
	typedef logic [3:0] dbg_nibble_t;

	// ------------------------------------------------------------
	// state machines
	// ------------------------------------------------------------

	typedef enum logic [2:0] {
		rx_st_idle,
		rx_st_start,
		rx_st_data,
		rx_st_stop,
		rx_st_wait_ack,
		rx_st_wait_idle
	} rx_state_t;

	typedef enum logic [1:0] {
		tx_st_idle,
		tx_st_start,
		tx_st_data,
		tx_st_stop
	} tx_state_t;

	typedef enum logic [1:0] {
		dbg_st_idle,
		dbg_st_halt,
		dbg_st_step,
		dbg_st_send
	} dbg_state_t;

endpackage

// File: hdl/dbg_uart_rx.sv
`timescale 1ns/100ps

`include "dbg_uart_settings.svh"

module dbg_uart_rx (
	input  logic                  uart_clk,
	input  logic                  reset,
	input  logic                  rx,
	input  logic                  rx_release,
	output logic                  rx_valid,
	output dbg_uart_pkg::dbg_byte_t rx_byte,
	output logic                  rx_frame_ok,
	output logic                  cts
);
	import dbg_uart_pkg::*;

	localparam int sub_w = $clog2(`DBG_BAUD_DIV);
	localparam logic [sub_w-1:0] sub_last = sub_w'(`DBG_BAUD_DIV - 1);
	localparam logic [sub_w-1:0] sub_half = sub_w'(`DBG_BAUD_DIV / 2);

	rx_state_t        state;
	logic [sub_w-1:0] sub_count;
	logic [2:0]       bit_idx;
	logic             sub_done;

	assign sub_done = (sub_count == sub_last);

	always_ff @(posedge uart_clk) begin
		if (reset) begin
			state    <= rx_st_wait_idle;
			rx_valid <= 1'b0;
			cts      <= 1'b0;
		end else begin
			case (state)
			rx_st_idle:
				// falling edge starts the count at half a bit
				if (!rx) begin
					state     <= rx_st_start;
					sub_count <= sub_half;
				end
			rx_st_start:
				if (sub_done) begin
					sub_count <= '0;
					bit_idx   <= 3'd0;
					// a start bit that is high at mid-bit was a glitch
					if (!rx) begin
						state <= rx_st_data;
						cts   <= 1'b1;
					end else begin
						state <= rx_st_idle;
					end
				end else begin
					sub_count <= sub_count + 1'b1;
				end
			rx_st_data:
				if (sub_done) begin
					sub_count <= '0;
					rx_byte   <= {rx, rx_byte[7:1]};
					if (bit_idx == 3'd7)
						state <= rx_st_stop;
					else
						bit_idx <= bit_idx + 1'b1;
				end else begin
					sub_count <= sub_count + 1'b1;
				end
			rx_st_stop:
				if (sub_done) begin
					rx_frame_ok <= rx;
					rx_valid    <= 1'b1;
					state       <= rx_st_wait_ack;
				end else begin
					sub_count <= sub_count + 1'b1;
				end
			rx_st_wait_ack:
				// line is ignored while the byte is held
				if (rx_release) begin
					rx_valid <= 1'b0;
					state    <= rx_st_wait_idle;
				end
			rx_st_wait_idle:
				if (rx) begin
					state <= rx_st_idle;
					cts   <= 1'b0;
				end
			default:
				state <= rx_st_wait_idle;
			endcase
		end
	end

endmodule

// File: hdl/dbg_uart_tx.sv
`timescale 1ns/100ps

`include "dbg_uart_settings.svh"

module dbg_uart_tx (
	input  logic                    uart_clk,
	input  logic                    reset,
	input  logic                    tx_start,
	input  dbg_uart_pkg::dbg_byte_t tx_byte,
	output logic                    tx_busy,
	output logic                    tx
);
	import dbg_uart_pkg::*;

	localparam int sub_w = $clog2(`DBG_BAUD_DIV);
	localparam logic [sub_w-1:0] sub_last = sub_w'(`DBG_BAUD_DIV - 1);

	tx_state_t        state;
	logic [sub_w-1:0] sub_count;
	logic [2:0]       bit_idx;
	dbg_byte_t        shift;
	logic             sub_done;

	assign sub_done = (sub_count == sub_last);

	// busy from the cycle after tx_start to the end of the stop bit
	assign tx_busy = (state != tx_st_idle);

	always_ff @(posedge uart_clk) begin
		if (reset) begin
			state <= tx_st_idle;
			tx    <= 1'b1;
		end else begin
			case (state)
			tx_st_idle:
				if (tx_start) begin
					shift     <= tx_byte;
					sub_count <= '0;
					tx        <= 1'b0;
					state     <= tx_st_start;
				end
			tx_st_start:
				if (sub_done) begin
					sub_count <= '0;
					bit_idx   <= 3'd0;
					tx        <= shift[0];
					shift     <= {1'b0, shift[7:1]};
					state     <= tx_st_data;
				end else begin
					sub_count <= sub_count + 1'b1;
				end
			tx_st_data:
				if (sub_done) begin
					sub_count <= '0;
					if (bit_idx == 3'd7) begin
						tx    <= 1'b1;
						state <= tx_st_stop;
					end else begin
						bit_idx <= bit_idx + 1'b1;
						tx      <= shift[0];
						shift   <= {1'b0, shift[7:1]};
					end
				end else begin
					sub_count <= sub_count + 1'b1;
				end
			tx_st_stop:
				if (sub_done)
					state <= tx_st_idle;
				else
					sub_count <= sub_count + 1'b1;
			default:
				state <= tx_st_idle;
			endcase
		end
	end

endmodule

// File: hdl/dbg_cmd_ctrl.sv
`timescale 1ns/100ps

`include "dbg_uart_settings.svh"

module dbg_cmd_ctrl (
	input  logic                      uart_clk,
	input  logic                      reset,
	input  logic                      rx_valid,
	input  dbg_uart_pkg::dbg_byte_t   rx_byte,
	input  logic                      rx_frame_ok,
	output logic                      rx_release,
	output logic                      tx_start,
	output dbg_uart_pkg::dbg_byte_t   tx_byte,
	input  logic                      tx_busy,
	input  dbg_uart_pkg::dbg_byte_t   probe,
	input  dbg_uart_pkg::dbg_addr_t   pc,
	input  dbg_uart_pkg::dbg_addr_t   sp,
	input  dbg_uart_pkg::dbg_nibble_t flags,
	output logic                      halt,
	output logic                      no_inc,
	output logic                      drv,
	output dbg_uart_pkg::dbg_byte_t   data
);
	import dbg_uart_pkg::*;

	localparam int cyc_w = $clog2(`DBG_INJECT_DEPTH);
	localparam logic [cyc_w-1:0] cyc_last = cyc_w'(`DBG_INJECT_DEPTH - 1);

	dbg_state_t       state;
	logic [cyc_w-1:0] cycle;
	dbg_nibble_t      ret;
	dbg_nibble_t      prep;
	dbg_byte_t        staged;
	dbg_addr_t        bp [`DBG_NUM_BP];
	logic [8:0]       mem [`DBG_INJECT_DEPTH];

	logic cmd_valid;
	logic cmd_accept;
	logic is_halt;
	logic is_ctl;
	logic is_cont;
	logic is_step;
	logic is_stage;
	logic is_noinc;
	logic is_inject;
	logic is_bp;
	logic step_go;
	logic bp_hit;

	// ------------------------------------------------------------
	// command decode
	// ------------------------------------------------------------

	// release pulse still high means the held byte was already handled
	assign cmd_valid  = (state == dbg_st_idle) && rx_valid && !rx_release;
	assign cmd_accept = cmd_valid && rx_frame_ok;

	assign is_halt   = (rx_byte == 8'h00);
	assign is_ctl    = (rx_byte[7:4] == 4'h0) && !is_halt;
	assign is_cont   = is_ctl && (rx_byte[1:0] == 2'b11);
	assign is_step   = is_ctl && (rx_byte[1:0] == 2'b10);
	assign is_stage  = (rx_byte[7:4] == 4'h1);
	assign is_noinc  = (rx_byte[7:5] == 3'b001);
	assign is_inject = (rx_byte[7:6] == 2'b01);
	assign is_bp     = rx_byte[7];

	assign step_go = cmd_accept && is_step && halt;

	always_comb begin
		bp_hit = 1'b0;
		for (int i = 0; i < `DBG_NUM_BP; i++)
			if (pc == bp[i])
				bp_hit = 1'b1;
	end

	// ------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------

	always_ff @(posedge uart_clk) begin
		if (reset) begin
			state      <= dbg_st_idle;
			cycle      <= '0;
			ret        <= '0;
			halt       <= 1'b0;
			no_inc     <= 1'b0;
			tx_start   <= 1'b0;
			rx_release <= 1'b0;
			for (int i = 0; i < `DBG_NUM_BP; i++)
				bp[i] <= 16'hffff;
		end else begin
			tx_start   <= 1'b0;
			rx_release <= 1'b0;
			case (state)
			dbg_st_idle:
				if (cmd_valid) begin
					// drop a bad frame or a step while running without a report
					if (!rx_frame_ok || (is_step && !halt)) begin
						rx_release <= 1'b1;
					end else if (is_halt) begin
						halt  <= 1'b1;
						cycle <= '0;
						state <= dbg_st_halt;
					end else if (is_step) begin
						halt  <= 1'b0;
						cycle <= '0;
						state <= dbg_st_step;
					end else begin
						if (is_cont) begin
							halt   <= 1'b0;
							no_inc <= 1'b0;
						end
						if (is_noinc && halt)
							no_inc <= rx_byte[1];
						if (is_bp)
							for (int i = 0; i < `DBG_NUM_BP; i++)
								if (int'(rx_byte[6:4]) == i)
									bp[i] <= {rx_byte[3:0], bp[i][15:4]};
						tx_start <= 1'b1;
						state    <= dbg_st_send;
					end
				end
			dbg_st_halt:
				if (cycle == cyc_last) begin
					tx_start <= 1'b1;
					state    <= dbg_st_send;
				end else begin
					cycle <= cycle + 1'b1;
				end
			dbg_st_step:
				begin
					// cpu runs for the first window cycle only
					halt <= 1'b1;
					if (cycle == cyc_last) begin
						tx_start <= 1'b1;
						state    <= dbg_st_send;
					end else begin
						cycle <= cycle + 1'b1;
					end
				end
			dbg_st_send:
				if (!tx_start && !tx_busy) begin
					rx_release <= 1'b1;
					ret        <= ret + 1'b1;
					state      <= dbg_st_idle;
				end
			default:
				state <= dbg_st_idle;
			endcase

			if (bp_hit && !step_go)
				halt <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// staged byte and injection memory
	// ------------------------------------------------------------

	always_ff @(posedge uart_clk) begin
		if (cmd_accept && is_stage)
			staged <= {rx_byte[3:0], staged[7:4]};
		if (cmd_accept && is_inject && (rx_byte[4:0] < 5'(`DBG_INJECT_DEPTH)))
			mem[rx_byte[4:0]] <= {rx_byte[5], staged};
	end

	// window cycle k puts entry k on the bus
	assign drv  = (state == dbg_st_step) && mem[cycle][8];
	assign data = mem[cycle][7:0];

	// ------------------------------------------------------------
	// report byte
	// ------------------------------------------------------------

	always_comb begin
		case (ret)
		4'd0:    prep = {2'b00, no_inc, halt};
		4'd1:    prep = flags;
		4'd2:    prep = probe[3:0];
		4'd3:    prep = probe[7:4];
		4'd4:    prep = pc[3:0];
		4'd5:    prep = pc[7:4];
		4'd6:    prep = pc[11:8];
		4'd7:    prep = pc[15:12];
		4'd8:    prep = sp[3:0];
		4'd9:    prep = sp[7:4];
		4'd10:   prep = sp[11:8];
		4'd11:   prep = sp[15:12];
		default: prep = 4'ha;
		endcase
	end

	// latched by the transmitter on tx_start
	assign tx_byte = {ret, prep};

endmodule

// File: hdl/lr35902_dbg_uart.sv
`timescale 1ns/100ps

module lr35902_dbg_uart (
	input  logic                      uart_clk,
	input  logic                      reset,
	input  logic                      rx,
	input  dbg_uart_pkg::dbg_byte_t   probe,
	input  dbg_uart_pkg::dbg_addr_t   pc,
	input  dbg_uart_pkg::dbg_addr_t   sp,
	input  dbg_uart_pkg::dbg_nibble_t flags,
	output logic                      tx,
	output logic                      cts,
	output logic                      halt,
	output logic                      no_inc,
	output logic                      drv,
	output dbg_uart_pkg::dbg_byte_t   data
);
	import dbg_uart_pkg::*;

	logic      rx_valid;
	dbg_byte_t rx_byte;
	logic      rx_frame_ok;
	logic      rx_release;
	logic      tx_start;
	dbg_byte_t tx_byte;
	logic      tx_busy;

	dbg_uart_rx dbg_uart_rx_inst (
		.uart_clk    (uart_clk),
		.reset       (reset),
		.rx          (rx),
		.rx_release  (rx_release),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.rx_frame_ok (rx_frame_ok),
		.cts         (cts)
	);

	dbg_cmd_ctrl dbg_cmd_ctrl_inst (
		.uart_clk    (uart_clk),
		.reset       (reset),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.rx_frame_ok (rx_frame_ok),
		.rx_release  (rx_release),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte),
		.tx_busy     (tx_busy),
		.probe       (probe),
		.pc          (pc),
		.sp          (sp),
		.flags       (flags),
		.halt        (halt),
		.no_inc      (no_inc),
		.drv         (drv),
		.data        (data)
	);

	dbg_uart_tx dbg_uart_tx_inst (
		.uart_clk (uart_clk),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_busy  (tx_busy),
		.tx       (tx)
	);

endmodule

// File: verif/dbg_uart_clkgen.sv
`timescale 1ns/100ps

module dbg_uart_clkgen (
	output logic uart_clk,
	output logic reset
);

	// 40 ns period
	initial begin
		uart_clk = 1'b0;
		forever #20 uart_clk = ~uart_clk;
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge uart_clk);
		#2;
		reset = 1'b0;
	end

endmodule

// File: verif/dbg_uart_tb.sv
`timescale 1ns/100ps

`include "dbg_uart_settings.svh"

module dbg_uart_tb;
	import dbg_uart_pkg::*;

	localparam int baud = `DBG_BAUD_DIV;
	localparam int depth = `DBG_INJECT_DEPTH;
	localparam int frame_cycles = 10 * baud;
	// host frame, step window, report frame and some slack per command
	localparam int cmd_cycles = 2 * frame_cycles + depth + 16;
	localparam int num_cmds = 16 + 18 + 3 * depth + 2 + `DBG_NUM_BP + 1 + 2;
	localparam int idle_cycles = 6 * frame_cycles + 64;
	localparam int watchdog_cycles = 2 * (num_cmds * cmd_cycles + idle_cycles);

	logic        uart_clk;
	logic        reset;
	logic        rx;
	logic        tx;
	logic        cts;
	logic        halt;
	logic        no_inc;
	logic        drv;
	dbg_byte_t   probe;
	dbg_byte_t   data;
	dbg_addr_t   pc;
	dbg_addr_t   sp;
	dbg_addr_t   bp_addr;
	dbg_nibble_t flags;

	// model of the report counter and the control bits
	dbg_nibble_t model_cnt;
	logic        model_halt;
	logic        model_no_inc;
	bit          hold_pc;
	logic [31:0] lcg_state;
	dbg_byte_t   reports [$];
	dbg_byte_t   inj_data [depth];
	logic        inj_drv [depth];
	string       test_name;

	dbg_uart_clkgen dbg_uart_clkgen_inst (
		.uart_clk (uart_clk),
		.reset    (reset)
	);

	lr35902_dbg_uart lr35902_dbg_uart_inst (
		.uart_clk (uart_clk),
		.reset    (reset),
		.rx       (rx),
		.probe    (probe),
		.pc       (pc),
		.sp       (sp),
		.flags    (flags),
		.tx       (tx),
		.cts      (cts),
		.halt     (halt),
		.no_inc   (no_inc),
		.drv      (drv),
		.data     (data)
	);

	// ------------------------------------------------------------
	// failure handling and checks
	// ------------------------------------------------------------

	task automatic stop_on_failure();
		$display("Checks failed");
		$fatal(1, "stopping at the first failed check");
	endtask

	task automatic report_mismatch(input logic [15:0] exp, input logic [15:0] act);
		$display("MISMATCH %s expected 0x%0h actual 0x%0h", test_name, exp, act);
		stop_on_failure();
	endtask

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		stop_on_failure();
	endtask

	task automatic expect_equal(input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else report_mismatch(exp, act);
	endtask

	assert property (@(posedge uart_clk) reset |=> (tx && !cts && !halt && !no_inc && !drv))
		else report_error("outputs are not at their reset values");

	assert property (@(posedge uart_clk) disable iff (reset) $rose(no_inc) |-> halt)
		else report_error("no_inc was set while the cpu was running");

	assert property (@(posedge uart_clk) disable iff (reset) $rose(cts) |-> !rx)
		else report_error("cts rose without a start bit on rx");

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic wait_drive_slot();
		@(posedge uart_clk);
		#2;
	endtask

	task automatic drive_pc(input dbg_addr_t value);
		wait_drive_slot();
		pc = value;
	endtask

	task automatic randomize_inputs();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		r1 = next_random();
		r2 = next_random();
		r3 = next_random();
		wait_drive_slot();
		probe = r1[31:24];
		flags = r1[23:20];
		sp    = r3[31:16];
		// 0xffff would hit the reset value of every breakpoint
		if (!hold_pc)
			pc = (r2[31:16] == 16'hffff) ? 16'hfffe : r2[31:16];
	endtask

	// report byte as the host expects it for counter value cnt
	function automatic dbg_byte_t expected_report(input dbg_nibble_t cnt);
		dbg_nibble_t low;
		case (cnt)
		4'd0:    low = {2'b00, model_no_inc, model_halt};
		4'd1:    low = flags;
		4'd2:    low = probe[3:0];
		4'd3:    low = probe[7:4];
		4'd4:    low = pc[3:0];
		4'd5:    low = pc[7:4];
		4'd6:    low = pc[11:8];
		4'd7:    low = pc[15:12];
		4'd8:    low = sp[3:0];
		4'd9:    low = sp[7:4];
		4'd10:   low = sp[11:8];
		4'd11:   low = sp[15:12];
		default: low = 4'ha;
		endcase
		return {cnt, low};
	endfunction

	task automatic drive_bit(input logic value);
		wait_drive_slot();
		rx = value;
		repeat (baud - 1) @(posedge uart_clk);
	endtask

	task automatic send_serial_byte(input dbg_byte_t value, input logic stop_bit);
		while (cts !== 1'b0)
			@(negedge uart_clk);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(value[i]);
		drive_bit(stop_bit);
		wait_drive_slot();
		rx = 1'b1;
	endtask

	// decodes one 8N1 frame on tx with samples at mid-bit
	task automatic receive_report(output dbg_byte_t value);
		do
			@(negedge uart_clk);
		while (tx !== 1'b0);
		repeat (baud / 2) @(negedge uart_clk);
		assert (tx === 1'b0) else report_error("report start bit did not last to mid-bit");
		for (int i = 0; i < 8; i++) begin
			repeat (baud) @(negedge uart_clk);
			value[i] = tx;
		end
		repeat (baud) @(negedge uart_clk);
		assert (tx === 1'b1) else report_error("report stop bit was low");
	endtask

	task automatic check_next_report();
		dbg_byte_t got;
		while (reports.size() == 0)
			@(negedge uart_clk);
		got = reports.pop_front();
		expect_equal(expected_report(model_cnt), got);
		expect_equal(model_halt, halt);
		expect_equal(model_no_inc, no_inc);
		model_cnt = model_cnt + 1'b1;
	endtask

	task automatic send_and_check(input dbg_byte_t cmd);
		randomize_inputs();
		send_serial_byte(cmd, 1'b1);
		check_next_report();
	endtask

	task automatic expect_no_report();
		while (cts !== 1'b0)
			@(negedge uart_clk);
		repeat (frame_cycles) @(negedge uart_clk);
		expect_equal(16'd0, 16'(reports.size()));
	endtask

	// no-ops until the status report at counter 0 has been checked
	task automatic run_to_status_report();
		do
			send_and_check(8'h01);
		while (model_cnt != 4'd1);
	endtask

	task automatic check_step_window();
		while (halt !== 1'b0)
			@(negedge uart_clk);
		for (int k = 0; k < depth; k++) begin
			expect_equal(inj_drv[k], drv);
			expect_equal(inj_data[k], data);
			expect_equal(k != 0, halt);
			@(negedge uart_clk);
		end
		expect_equal(1'b0, drv);
		expect_equal(1'b1, halt);
	endtask

	// ------------------------------------------------------------
	// report monitor and watchdog
	// ------------------------------------------------------------

	initial begin
		dbg_byte_t value;
		forever begin
			receive_report(value);
			reports.push_back(value);
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge uart_clk);
		$display("ERROR watchdog expired before the tests finished");
		stop_on_failure();
	end

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------

	initial begin
		logic [31:0] r;
		rx           = 1'b1;
		probe        = '0;
		pc           = '0;
		sp           = '0;
		flags        = '0;
		lcg_state    = 32'hf42b_b56e;
		model_cnt    = '0;
		model_halt   = 1'b0;
		model_no_inc = 1'b0;
		hold_pc      = 1'b0;

		test_name = "reset";
		wait (reset === 1'b0);
		@(negedge uart_clk);
		expect_equal(1'b1, tx);
		expect_equal(1'b0, cts);
		expect_equal(1'b0, halt);
		expect_equal(1'b0, no_inc);
		expect_equal(1'b0, drv);
		repeat (2 * frame_cycles) @(negedge uart_clk);
		expect_equal(16'd0, 16'(reports.size()));

		test_name = "report_sequence";
		model_halt = 1'b1;
		send_and_check(8'h00);
		for (int i = 1; i < 16; i++)
			send_and_check(8'h01);

		test_name = "no_inc_continue";
		model_no_inc = 1'b1;
		send_and_check(8'h22);
		model_halt   = 1'b0;
		model_no_inc = 1'b0;
		send_and_check(8'h03);
		// no_inc only follows bit 1 while halted
		send_and_check(8'h22);
		run_to_status_report();
		// step while running is dropped
		send_serial_byte(8'h02, 1'b1);
		expect_no_report();
		expect_equal(1'b0, halt);

		test_name = "step_inject";
		for (int k = 0; k < depth; k++) begin
			r = next_random();
			inj_data[k] = r[31:24];
			inj_drv[k]  = r[19];
			send_and_check({4'h1, inj_data[k][3:0]});
			send_and_check({4'h1, inj_data[k][7:4]});
			send_and_check({2'b01, inj_drv[k], 5'(k)});
		end
		model_halt = 1'b1;
		send_and_check(8'h00);
		fork
			send_serial_byte(8'h02, 1'b1);
			check_step_window();
		join
		check_next_report();
		expect_no_report();

		test_name = "breakpoint";
		hold_pc = 1'b1;
		drive_pc(16'h0000);
		r = next_random();
		bp_addr = (r[31:16] & 16'h7fff) | 16'h0001;
		for (int n = 0; n < 4; n++)
			send_and_check({1'b1, 3'd2, bp_addr[4*n +: 4]});
		model_halt = 1'b0;
		send_and_check(8'h03);
		drive_pc(bp_addr ^ 16'h0100);
		repeat (4) @(negedge uart_clk);
		expect_equal(1'b0, halt);
		drive_pc(bp_addr);
		repeat (2) @(negedge uart_clk);
		expect_equal(1'b1, halt);
		model_halt = 1'b1;
		drive_pc(16'h0000);

		test_name = "bad_frame";
		send_serial_byte(8'h03, 1'b0);
		expect_no_report();
		expect_equal(1'b1, halt);
		send_and_check(8'h01);

		$display("All checks passed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+hdl
hdl/dbg_uart_pkg.sv
hdl/dbg_uart_rx.sv
hdl/dbg_uart_tx.sv
hdl/dbg_cmd_ctrl.sv
hdl/lr35902_dbg_uart.sv
verif/dbg_uart_clkgen.sv
verif/dbg_uart_tb.sv

// File: Bender.yml
package:
  name: lr35902_dbg_uart

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dbg_uart_pkg.sv
      - hdl/dbg_uart_rx.sv
      - hdl/dbg_uart_tx.sv
      - hdl/dbg_cmd_ctrl.sv
      - hdl/lr35902_dbg_uart.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/dbg_uart_clkgen.sv
      - verif/dbg_uart_tb.sv
